// File: common/piano_ctrl_defines.svh
`ifndef PIANO_CTRL_DEFINES_SVH
`define PIANO_CTRL_DEFINES_SVH

// Width of the control state code
`define PIANO_STATE_W 6

// Width of the menu page selector
`define PIANO_MENU_W 3

`endif

// File: common/piano_ctrl_pkg.sv
`include "piano_ctrl_defines.svh"

package piano_ctrl_pkg;

    typedef logic [`PIANO_STATE_W-1:0] state_code_t;
    typedef logic [`PIANO_MENU_W-1:0]  page_code_t;

    // ----------------------------------------------------------------------
    // Controller state codes
    // ----------------------------------------------------------------------
    typedef enum state_code_t {
        ST_IDLE             = 6'h00,
        ST_INIT             = 6'h01,
        ST_START_ROUND      = 6'h02,
        ST_SHOW             = 6'h03,
        ST_SHOW_WAIT        = 6'h04,
        ST_NEXT_SHOW        = 6'h05,
        ST_START_ANSWER     = 6'h06,
        ST_ANSWER_WAIT      = 6'h07,
        ST_COMPARE          = 6'h09,
        ST_WON_GAME         = 6'h0A,
        ST_NEXT_NOTE        = 6'h0B,
        ST_ADD_NOTE         = 6'h13,
        ST_MISSED_NOTE      = 6'h14,
        ST_MISSED_TIME      = 6'h15,
        ST_NOTE_PLAY        = 6'h17,
        ST_SHOW_LAST        = 6'h18,
        ST_NEXT_ROUND       = 6'h19,
        ST_CHECK_END        = 6'h1A,
        ST_SAVE_ROUND       = 6'h1B,
        ST_BEGIN_MENU       = 6'h1C,
        ST_WAIT_MODE        = 6'h1D,
        ST_WAIT_TEMPO       = 6'h1E,
        ST_WAIT_KEY         = 6'h1F,
        ST_WAIT_SONG        = 6'h20,
        ST_BEGIN_ERROR_MENU = 6'h21,
        ST_ERROR_MENU       = 6'h22,
        ST_FREE_WAIT        = 6'h23
    } ctrl_state_t;

    typedef enum logic {
        MODE_REPEAT = 1'b0,
        MODE_FREE   = 1'b1
    } play_mode_t;

    // Player choice in the error menu
    typedef enum logic [1:0] {
        RETRY_NONE      = 2'd0,
        RETRY_ROUND     = 2'd1,
        RETRY_NOTE      = 2'd2,
        RETRY_SHOW_LAST = 2'd3
    } retry_t;

    typedef enum page_code_t {
        PAGE_MODE  = 3'd0,
        PAGE_TEMPO = 3'd1,
        PAGE_KEY   = 3'd2,
        PAGE_SONG  = 3'd3,
        PAGE_ERROR = 3'd4
    } menu_page_t;

    // ----------------------------------------------------------------------
    // Datapath interface
    // ----------------------------------------------------------------------
    typedef struct packed {
        logic show_delay_done;
        logic round_done;
        logic note_held;
        logic note_right;
        logic timing_right;
        logic beat_low;
        logic addr_at_round;
        logic answer_timeout;
        logic song_end;
    } ctrl_status_t;

    typedef struct packed {
        logic       clear_note_counter;
        logic       count_note_counter;
        logic       clear_show_delay;
        logic       count_show_delay;
        logic       clear_round_counter;
        logic       count_round_counter;
        logic       clear_metronome;
        logic       count_metronome;
        logic       clear_answer_timer;
        logic       count_answer_timer;
        logic       store_note;
        logic       clear_note_reg;
        logic       clear_options;
        logic       leds_from_memory;
        logic       leds_on;
        logic       play_tone;
        logic       start_menu;
        logic       show_menu;
        menu_page_t menu_page;
        logic       store_mode;
        logic       store_tempo;
        logic       store_key;
        logic       store_song;
        logic       store_error;
    } ctrl_cmd_t;

    typedef struct packed {
        logic won;
        logic lost;
        logic player_turn;
    } player_status_t;

endpackage

// File: control/menu_next_state.sv
module menu_next_state (
    input  piano_ctrl_pkg::ctrl_state_t state,
    input  logic                        start,
    input  logic                        enter,
    input  piano_ctrl_pkg::play_mode_t  mode,
    output piano_ctrl_pkg::ctrl_state_t menu_next,
    output logic                        in_menu
);

    // Idle and the setup pages
    assign in_menu = state inside {
        piano_ctrl_pkg::ST_IDLE,
        piano_ctrl_pkg::ST_BEGIN_MENU,
        piano_ctrl_pkg::ST_WAIT_MODE,
        piano_ctrl_pkg::ST_WAIT_TEMPO,
        piano_ctrl_pkg::ST_WAIT_KEY,
        piano_ctrl_pkg::ST_WAIT_SONG
    };

    always_comb begin
        case (state)
            piano_ctrl_pkg::ST_IDLE:
                menu_next = start ? piano_ctrl_pkg::ST_BEGIN_MENU
                                  : piano_ctrl_pkg::ST_IDLE;
            piano_ctrl_pkg::ST_BEGIN_MENU:
                menu_next = piano_ctrl_pkg::ST_WAIT_MODE;
            piano_ctrl_pkg::ST_WAIT_MODE:
                menu_next = enter ? piano_ctrl_pkg::ST_WAIT_TEMPO
                                  : piano_ctrl_pkg::ST_WAIT_MODE;
            piano_ctrl_pkg::ST_WAIT_TEMPO:
                menu_next = enter ? piano_ctrl_pkg::ST_WAIT_KEY
                                  : piano_ctrl_pkg::ST_WAIT_TEMPO;
            piano_ctrl_pkg::ST_WAIT_KEY: begin
                // No song to pick in free play
                if (!enter) begin
                    menu_next = piano_ctrl_pkg::ST_WAIT_KEY;
                end else if (mode == piano_ctrl_pkg::MODE_FREE) begin
                    menu_next = piano_ctrl_pkg::ST_INIT;
                end else begin
                    menu_next = piano_ctrl_pkg::ST_WAIT_SONG;
                end
            end
            piano_ctrl_pkg::ST_WAIT_SONG:
                menu_next = enter ? piano_ctrl_pkg::ST_INIT
                                  : piano_ctrl_pkg::ST_WAIT_SONG;
            default:
                menu_next = piano_ctrl_pkg::ST_INIT;
        endcase
    end

endmodule

// File: control/play_next_state.sv
module play_next_state (
    input  piano_ctrl_pkg::ctrl_state_t  state,
    input  piano_ctrl_pkg::play_mode_t   mode,
    input  piano_ctrl_pkg::retry_t       retry,
    input  logic                         start,
    input  logic                         enter,
    input  piano_ctrl_pkg::ctrl_status_t status,
    output piano_ctrl_pkg::ctrl_state_t  play_next
);

    piano_ctrl_pkg::ctrl_state_t repeat_next;
    piano_ctrl_pkg::ctrl_state_t free_next;
    piano_ctrl_pkg::ctrl_state_t retry_next;
    piano_ctrl_pkg::ctrl_state_t compare_next;

    // ----------------------------------------------------------------------
    // Error menu choice
    // ----------------------------------------------------------------------
    always_comb begin
        case (retry)
            piano_ctrl_pkg::RETRY_ROUND:     retry_next = piano_ctrl_pkg::ST_START_ROUND;
            piano_ctrl_pkg::RETRY_NOTE:      retry_next = piano_ctrl_pkg::ST_START_ANSWER;
            piano_ctrl_pkg::RETRY_SHOW_LAST: retry_next = piano_ctrl_pkg::ST_SHOW_LAST;
            default:                         retry_next = piano_ctrl_pkg::ST_ERROR_MENU;
        endcase
    end

    // Note first, then timing, then position in the round
    always_comb begin
        if (!status.note_right) begin
            compare_next = piano_ctrl_pkg::ST_MISSED_NOTE;
        end else if (!status.timing_right) begin
            compare_next = piano_ctrl_pkg::ST_MISSED_TIME;
        end else if (status.addr_at_round) begin
            compare_next = status.round_done ? piano_ctrl_pkg::ST_WON_GAME
                                             : piano_ctrl_pkg::ST_ADD_NOTE;
        end else begin
            compare_next = piano_ctrl_pkg::ST_NEXT_NOTE;
        end
    end

    // ----------------------------------------------------------------------
    // Repeat the melody
    // ----------------------------------------------------------------------
    always_comb begin
        case (state)
            piano_ctrl_pkg::ST_INIT:
                repeat_next = piano_ctrl_pkg::ST_START_ROUND;
            piano_ctrl_pkg::ST_START_ROUND:
                repeat_next = status.show_delay_done ? piano_ctrl_pkg::ST_SHOW
                                                     : piano_ctrl_pkg::ST_START_ROUND;
            piano_ctrl_pkg::ST_SHOW:
                repeat_next = piano_ctrl_pkg::ST_SHOW_WAIT;
            piano_ctrl_pkg::ST_SHOW_WAIT: begin
                if (!status.beat_low) begin
                    repeat_next = piano_ctrl_pkg::ST_SHOW_WAIT;
                end else if (status.addr_at_round) begin
                    repeat_next = piano_ctrl_pkg::ST_START_ANSWER;
                end else begin
                    repeat_next = piano_ctrl_pkg::ST_NEXT_SHOW;
                end
            end
            piano_ctrl_pkg::ST_NEXT_SHOW:
                repeat_next = piano_ctrl_pkg::ST_SHOW;
            piano_ctrl_pkg::ST_START_ANSWER,
            piano_ctrl_pkg::ST_NEXT_NOTE:
                repeat_next = piano_ctrl_pkg::ST_ANSWER_WAIT;
            piano_ctrl_pkg::ST_ANSWER_WAIT: begin
                // Timeout wins over a late key press
                if (status.answer_timeout) begin
                    repeat_next = piano_ctrl_pkg::ST_MISSED_TIME;
                end else if (status.note_held) begin
                    repeat_next = piano_ctrl_pkg::ST_NOTE_PLAY;
                end else begin
                    repeat_next = piano_ctrl_pkg::ST_ANSWER_WAIT;
                end
            end
            piano_ctrl_pkg::ST_NOTE_PLAY:
                repeat_next = status.note_held ? piano_ctrl_pkg::ST_NOTE_PLAY
                                               : piano_ctrl_pkg::ST_COMPARE;
            piano_ctrl_pkg::ST_COMPARE:
                repeat_next = compare_next;
            piano_ctrl_pkg::ST_ADD_NOTE:
                repeat_next = piano_ctrl_pkg::ST_SAVE_ROUND;
            piano_ctrl_pkg::ST_SAVE_ROUND:
                repeat_next = piano_ctrl_pkg::ST_CHECK_END;
            piano_ctrl_pkg::ST_CHECK_END:
                repeat_next = status.song_end ? piano_ctrl_pkg::ST_WON_GAME
                                              : piano_ctrl_pkg::ST_NEXT_ROUND;
            piano_ctrl_pkg::ST_NEXT_ROUND:
                repeat_next = piano_ctrl_pkg::ST_START_ROUND;
            piano_ctrl_pkg::ST_MISSED_NOTE,
            piano_ctrl_pkg::ST_MISSED_TIME:
                repeat_next = piano_ctrl_pkg::ST_BEGIN_ERROR_MENU;
            piano_ctrl_pkg::ST_BEGIN_ERROR_MENU:
                repeat_next = piano_ctrl_pkg::ST_ERROR_MENU;
            piano_ctrl_pkg::ST_ERROR_MENU:
                repeat_next = enter ? retry_next : piano_ctrl_pkg::ST_ERROR_MENU;
            piano_ctrl_pkg::ST_SHOW_LAST:
                repeat_next = status.beat_low ? piano_ctrl_pkg::ST_ANSWER_WAIT
                                              : piano_ctrl_pkg::ST_SHOW_LAST;
            piano_ctrl_pkg::ST_WON_GAME:
                repeat_next = start ? piano_ctrl_pkg::ST_BEGIN_MENU
                                    : piano_ctrl_pkg::ST_WON_GAME;
            default:
                repeat_next = piano_ctrl_pkg::ST_IDLE;
        endcase
    end

    // Free play loops between waiting and sounding a key
    assign free_next = (status.note_held && state inside {piano_ctrl_pkg::ST_FREE_WAIT,
                                                          piano_ctrl_pkg::ST_NOTE_PLAY})
                     ? piano_ctrl_pkg::ST_NOTE_PLAY : piano_ctrl_pkg::ST_FREE_WAIT;

    assign play_next = (mode == piano_ctrl_pkg::MODE_FREE) ? free_next : repeat_next;

    a_retry_valid: assert final (
        !(state == piano_ctrl_pkg::ST_ERROR_MENU && enter) ||
        retry inside {piano_ctrl_pkg::RETRY_NONE, piano_ctrl_pkg::RETRY_ROUND,
                      piano_ctrl_pkg::RETRY_NOTE, piano_ctrl_pkg::RETRY_SHOW_LAST}
    );

endmodule

// File: control/state_register.sv
module state_register (
    input  logic                        clock,
    input  logic                        reset,
    input  logic                        in_menu,
    input  piano_ctrl_pkg::ctrl_state_t menu_next,
    input  piano_ctrl_pkg::ctrl_state_t play_next,
    output piano_ctrl_pkg::ctrl_state_t state
);

    piano_ctrl_pkg::ctrl_state_t next_state;

    // Menu logic owns the successor while in the setup pages
    assign next_state = in_menu ? menu_next : play_next;

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            state <= piano_ctrl_pkg::ST_IDLE;
        end else begin
            state <= next_state;
        end
    end

    // A known state means both successor paths resolve every condition
    a_state_known: assert property (
        @(posedge clock) disable iff (reset)
        !$isunknown(state)
    );

endmodule

// File: control/command_decoder.sv
module command_decoder (
    input  piano_ctrl_pkg::ctrl_state_t    state,
    output piano_ctrl_pkg::ctrl_cmd_t      cmd,
    output piano_ctrl_pkg::player_status_t player
);

    // ----------------------------------------------------------------------
    // Counters and timers
    // ----------------------------------------------------------------------
    always_comb begin
        cmd.clear_note_counter = state inside {piano_ctrl_pkg::ST_START_ROUND,
                                               piano_ctrl_pkg::ST_START_ANSWER};
        cmd.count_note_counter = state inside {piano_ctrl_pkg::ST_ADD_NOTE,
                                               piano_ctrl_pkg::ST_NEXT_SHOW,
                                               piano_ctrl_pkg::ST_NEXT_NOTE};
        cmd.clear_show_delay = state inside {piano_ctrl_pkg::ST_SHOW,
                                             piano_ctrl_pkg::ST_INIT,
                                             piano_ctrl_pkg::ST_START_ANSWER,
                                             piano_ctrl_pkg::ST_NEXT_ROUND};
        cmd.count_show_delay = (state == piano_ctrl_pkg::ST_START_ROUND);
        cmd.clear_round_counter = (state == piano_ctrl_pkg::ST_INIT);
        cmd.count_round_counter = (state == piano_ctrl_pkg::ST_NEXT_ROUND);
        cmd.clear_metronome = state inside {piano_ctrl_pkg::ST_SHOW,
                                            piano_ctrl_pkg::ST_MISSED_TIME,
                                            piano_ctrl_pkg::ST_MISSED_NOTE,
                                            piano_ctrl_pkg::ST_ANSWER_WAIT,
                                            piano_ctrl_pkg::ST_INIT,
                                            piano_ctrl_pkg::ST_CHECK_END};
        cmd.count_metronome = state inside {piano_ctrl_pkg::ST_SHOW_LAST,
                                            piano_ctrl_pkg::ST_SHOW_WAIT,
                                            piano_ctrl_pkg::ST_NOTE_PLAY,
                                            piano_ctrl_pkg::ST_FREE_WAIT};
        cmd.clear_answer_timer = state inside {piano_ctrl_pkg::ST_NEXT_NOTE,
                                               piano_ctrl_pkg::ST_START_ANSWER,
                                               piano_ctrl_pkg::ST_INIT,
                                               piano_ctrl_pkg::ST_MISSED_TIME,
                                               piano_ctrl_pkg::ST_MISSED_NOTE,
                                               piano_ctrl_pkg::ST_CHECK_END};
        cmd.count_answer_timer = (state == piano_ctrl_pkg::ST_ANSWER_WAIT);

        // Note register and option registers
        cmd.store_note     = (state == piano_ctrl_pkg::ST_NOTE_PLAY);
        cmd.clear_note_reg = (state == piano_ctrl_pkg::ST_IDLE);
        cmd.clear_options  = (state == piano_ctrl_pkg::ST_IDLE);

        // Keyboard lights and sound
        cmd.leds_from_memory = state inside {piano_ctrl_pkg::ST_SHOW_WAIT,
                                             piano_ctrl_pkg::ST_SHOW_LAST};
        cmd.leds_on = state inside {piano_ctrl_pkg::ST_NOTE_PLAY,
                                    piano_ctrl_pkg::ST_SHOW_WAIT,
                                    piano_ctrl_pkg::ST_SHOW_LAST};
        cmd.play_tone = (state == piano_ctrl_pkg::ST_NOTE_PLAY);

        // ------------------------------------------------------------------
        // Menu display
        // ------------------------------------------------------------------
        cmd.start_menu = state inside {piano_ctrl_pkg::ST_BEGIN_MENU,
                                       piano_ctrl_pkg::ST_BEGIN_ERROR_MENU};
        cmd.show_menu = state inside {piano_ctrl_pkg::ST_WAIT_MODE,
                                      piano_ctrl_pkg::ST_WAIT_TEMPO,
                                      piano_ctrl_pkg::ST_WAIT_KEY,
                                      piano_ctrl_pkg::ST_WAIT_SONG,
                                      piano_ctrl_pkg::ST_ERROR_MENU};
        case (state)
            piano_ctrl_pkg::ST_WAIT_TEMPO: cmd.menu_page = piano_ctrl_pkg::PAGE_TEMPO;
            piano_ctrl_pkg::ST_WAIT_KEY:   cmd.menu_page = piano_ctrl_pkg::PAGE_KEY;
            piano_ctrl_pkg::ST_WAIT_SONG:  cmd.menu_page = piano_ctrl_pkg::PAGE_SONG;
            piano_ctrl_pkg::ST_ERROR_MENU: cmd.menu_page = piano_ctrl_pkg::PAGE_ERROR;
            default:                       cmd.menu_page = piano_ctrl_pkg::PAGE_MODE;
        endcase
        cmd.store_mode  = (state == piano_ctrl_pkg::ST_WAIT_MODE);
        cmd.store_tempo = (state == piano_ctrl_pkg::ST_WAIT_TEMPO);
        cmd.store_key   = (state == piano_ctrl_pkg::ST_WAIT_KEY);
        cmd.store_song  = (state == piano_ctrl_pkg::ST_WAIT_SONG);
        cmd.store_error = (state == piano_ctrl_pkg::ST_COMPARE);
    end

    assign player.won  = (state == piano_ctrl_pkg::ST_WON_GAME);
    assign player.lost = state inside {piano_ctrl_pkg::ST_MISSED_NOTE,
                                       piano_ctrl_pkg::ST_MISSED_TIME};
    assign player.player_turn = (state == piano_ctrl_pkg::ST_ANSWER_WAIT);

    a_won_lost: assert final (!(player.won && player.lost));

    // Menu pages never overlap the answer window
    a_menu_turn: assert final (!(cmd.show_menu && player.player_turn));

endmodule

// File: control/piano_control.sv
module piano_control (
    input  logic                           clock,
    input  logic                           reset,
    input  logic                           start,
    input  logic                           enter,
    input  piano_ctrl_pkg::play_mode_t     mode,
    input  piano_ctrl_pkg::retry_t         retry,
    input  piano_ctrl_pkg::ctrl_status_t   status,
    output piano_ctrl_pkg::ctrl_cmd_t      cmd,
    output piano_ctrl_pkg::player_status_t player,
    output piano_ctrl_pkg::ctrl_state_t    debug_state
);

    piano_ctrl_pkg::ctrl_state_t state;
    piano_ctrl_pkg::ctrl_state_t menu_next;
    piano_ctrl_pkg::ctrl_state_t play_next;
    logic                        in_menu;

    menu_next_state menu_next_i (
        .state     (state),
        .start     (start),
        .enter     (enter),
        .mode      (mode),
        .menu_next (menu_next),
        .in_menu   (in_menu)
    );

    play_next_state play_next_i (
        .state     (state),
        .mode      (mode),
        .retry     (retry),
        .start     (start),
        .enter     (enter),
        .status    (status),
        .play_next (play_next)
    );

    state_register state_i (
        .clock     (clock),
        .reset     (reset),
        .in_menu   (in_menu),
        .menu_next (menu_next),
        .play_next (play_next),
        .state     (state)
    );

    command_decoder decoder_i (
        .state  (state),
        .cmd    (cmd),
        .player (player)
    );

    assign debug_state = state;

endmodule

// File: verif/tb_piano_tasks.svh
// ----------------------------------------------------------------------
// Random lengths, failure exit and compares
// ----------------------------------------------------------------------
function automatic int random_cycles(int max);
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return 1 + int'(lcg_state[23:16]) % max;
endfunction

task automatic fail_run(string why);
    $display("%s", why);
    $display("Test failed");
    $fatal(1, "Simulation stopped");
endtask

task automatic check_state(string name, piano_ctrl_pkg::ctrl_state_t got,
                           piano_ctrl_pkg::ctrl_state_t exp);
    if (got !== exp) begin
        $display("[FAIL] %0t %s: got %s (%h), expected %s", $time, name,
                 got.name(), got, exp.name());
        fail_run("Controller is in the wrong state");
    end
endtask

task automatic check_cmd(string name, piano_ctrl_pkg::ctrl_cmd_t got,
                         piano_ctrl_pkg::ctrl_cmd_t exp);
    if (got !== exp) begin
        $display("[FAIL] %0t %s: got %h, expected %h", $time, name, got, exp);
        fail_run("Command word differs");
    end
endtask

task automatic check_player(string name, piano_ctrl_pkg::player_status_t got,
                            piano_ctrl_pkg::player_status_t exp);
    if (got !== exp) begin
        $display("[FAIL] %0t %s: got %b, expected %b", $time, name, got, exp);
        fail_run("Player status differs");
    end
endtask

task automatic check_page(string name, piano_ctrl_pkg::menu_page_t got,
                          piano_ctrl_pkg::menu_page_t exp);
    if (got !== exp) begin
        $display("[FAIL] %0t %s: got %s, expected %s", $time, name, got.name(), exp.name());
        fail_run("Menu page differs");
    end
endtask

task automatic check_flag(string name, logic got, logic exp);
    if (got !== exp) begin
        $display("[FAIL] %0t %s: got %b, expected %b", $time, name, got, exp);
        fail_run("Command flag differs");
    end
endtask

// ----------------------------------------------------------------------
// Stepping helpers on the falling edge
// ----------------------------------------------------------------------
task automatic step_to(piano_ctrl_pkg::ctrl_state_t exp);
    @(negedge clock);
    check_state("debug_state", debug_state, exp);
endtask

task automatic hold_in(piano_ctrl_pkg::ctrl_state_t exp, int cycles);
    repeat (cycles) step_to(exp);
endtask

task automatic press_enter(piano_ctrl_pkg::ctrl_state_t from,
                           piano_ctrl_pkg::ctrl_state_t exp);
    hold_in(from, random_cycles(3));
    enter = 1'b1;
    step_to(exp);
    enter = 1'b0;
endtask

// From idle or won_game through the setup pages to init
task automatic walk_menu(piano_ctrl_pkg::play_mode_t m);
    start = 1'b1;
    step_to(piano_ctrl_pkg::ST_BEGIN_MENU);
    start = 1'b0;
    mode  = m;
    check_flag("cmd.start_menu", cmd.start_menu, 1'b1);
    step_to(piano_ctrl_pkg::ST_WAIT_MODE);
    check_flag("cmd.start_menu", cmd.start_menu, 1'b0);
    check_flag("cmd.show_menu", cmd.show_menu, 1'b1);
    check_flag("cmd.store_mode", cmd.store_mode, 1'b1);
    check_page("cmd.menu_page", cmd.menu_page, piano_ctrl_pkg::PAGE_MODE);
    press_enter(piano_ctrl_pkg::ST_WAIT_MODE, piano_ctrl_pkg::ST_WAIT_TEMPO);
    check_page("cmd.menu_page", cmd.menu_page, piano_ctrl_pkg::PAGE_TEMPO);
    press_enter(piano_ctrl_pkg::ST_WAIT_TEMPO, piano_ctrl_pkg::ST_WAIT_KEY);
    check_page("cmd.menu_page", cmd.menu_page, piano_ctrl_pkg::PAGE_KEY);
    if (m == piano_ctrl_pkg::MODE_FREE) begin
        press_enter(piano_ctrl_pkg::ST_WAIT_KEY, piano_ctrl_pkg::ST_INIT);
    end else begin
        press_enter(piano_ctrl_pkg::ST_WAIT_KEY, piano_ctrl_pkg::ST_WAIT_SONG);
        check_page("cmd.menu_page", cmd.menu_page, piano_ctrl_pkg::PAGE_SONG);
        check_flag("cmd.store_song", cmd.store_song, 1'b1);
        press_enter(piano_ctrl_pkg::ST_WAIT_SONG, piano_ctrl_pkg::ST_INIT);
    end
endtask

// Runs from start_round to answer_wait
task automatic show_melody(int notes);
    hold_in(piano_ctrl_pkg::ST_START_ROUND, random_cycles(4));
    check_flag("cmd.count_show_delay", cmd.count_show_delay, 1'b1);
    status.show_delay_done = 1'b1;
    step_to(piano_ctrl_pkg::ST_SHOW);
    status.show_delay_done = 1'b0;
    for (int i = 0; i < notes; i++) begin
        step_to(piano_ctrl_pkg::ST_SHOW_WAIT);
        check_flag("cmd.leds_from_memory", cmd.leds_from_memory, 1'b1);
        hold_in(piano_ctrl_pkg::ST_SHOW_WAIT, random_cycles(3));
        status.beat_low      = 1'b1;
        status.addr_at_round = (i == notes - 1);
        if (i == notes - 1) begin
            step_to(piano_ctrl_pkg::ST_START_ANSWER);
        end else begin
            step_to(piano_ctrl_pkg::ST_NEXT_SHOW);
            step_to(piano_ctrl_pkg::ST_SHOW);
        end
        status.beat_low      = 1'b0;
        status.addr_at_round = 1'b0;
    end
    step_to(piano_ctrl_pkg::ST_ANSWER_WAIT);
    // won, lost, player_turn
    check_player("player", player, 3'b001);
endtask

// One key press from answer_wait, judged in compare
task automatic answer_note(logic right, logic last, logic done,
                           piano_ctrl_pkg::ctrl_state_t exp_next);
    hold_in(piano_ctrl_pkg::ST_ANSWER_WAIT, random_cycles(3));
    status.note_held = 1'b1;
    step_to(piano_ctrl_pkg::ST_NOTE_PLAY);
    hold_in(piano_ctrl_pkg::ST_NOTE_PLAY, random_cycles(4) - 1);
    status.note_held     = 1'b0;
    status.note_right    = right;
    status.timing_right  = 1'b1;
    status.addr_at_round = last;
    status.round_done    = done;
    step_to(piano_ctrl_pkg::ST_COMPARE);
    check_flag("cmd.store_error", cmd.store_error, 1'b1);
    step_to(exp_next);
    status = '0;
endtask

// ----------------------------------------------------------------------
// Directed tests
// ----------------------------------------------------------------------
task automatic reset_and_setup_pages();
    piano_ctrl_pkg::ctrl_cmd_t exp;
    exp                = '0;
    exp.clear_note_reg = 1'b1;
    exp.clear_options  = 1'b1;
    exp.menu_page      = piano_ctrl_pkg::PAGE_MODE;
    check_state("debug_state", debug_state, piano_ctrl_pkg::ST_IDLE);
    check_cmd("cmd", cmd, exp);
    check_player("player", player, 3'b000);
    hold_in(piano_ctrl_pkg::ST_IDLE, random_cycles(4));
    walk_menu(piano_ctrl_pkg::MODE_REPEAT);
endtask

task automatic won_first_round();
    step_to(piano_ctrl_pkg::ST_START_ROUND);
    show_melody(2);
    answer_note(1'b1, 1'b0, 1'b0, piano_ctrl_pkg::ST_NEXT_NOTE);
    step_to(piano_ctrl_pkg::ST_ANSWER_WAIT);
    answer_note(1'b1, 1'b1, 1'b1, piano_ctrl_pkg::ST_WON_GAME);
    hold_in(piano_ctrl_pkg::ST_WON_GAME, random_cycles(4));
    check_player("player", player, 3'b100);
endtask

task automatic wrong_note_retry();
    walk_menu(piano_ctrl_pkg::MODE_REPEAT);
    step_to(piano_ctrl_pkg::ST_START_ROUND);
    show_melody(1);
    answer_note(1'b0, 1'b1, 1'b0, piano_ctrl_pkg::ST_MISSED_NOTE);
    check_player("player", player, 3'b010);
    step_to(piano_ctrl_pkg::ST_BEGIN_ERROR_MENU);
    check_player("player", player, 3'b000);
    step_to(piano_ctrl_pkg::ST_ERROR_MENU);
    check_flag("cmd.show_menu", cmd.show_menu, 1'b1);
    check_page("cmd.menu_page", cmd.menu_page, piano_ctrl_pkg::PAGE_ERROR);
    // No choice made yet
    enter = 1'b1;
    step_to(piano_ctrl_pkg::ST_ERROR_MENU);
    retry = piano_ctrl_pkg::RETRY_NOTE;
    step_to(piano_ctrl_pkg::ST_START_ANSWER);
    enter = 1'b0;
    check_flag("cmd.clear_answer_timer", cmd.clear_answer_timer, 1'b1);
    check_player("player", player, 3'b000);
    step_to(piano_ctrl_pkg::ST_ANSWER_WAIT);
    check_player("player", player, 3'b001);
endtask

task automatic timeout_show_last();
    hold_in(piano_ctrl_pkg::ST_ANSWER_WAIT, random_cycles(4));
    status.answer_timeout = 1'b1;
    step_to(piano_ctrl_pkg::ST_MISSED_TIME);
    status.answer_timeout = 1'b0;
    check_player("player", player, 3'b010);
    step_to(piano_ctrl_pkg::ST_BEGIN_ERROR_MENU);
    step_to(piano_ctrl_pkg::ST_ERROR_MENU);
    retry = piano_ctrl_pkg::RETRY_SHOW_LAST;
    press_enter(piano_ctrl_pkg::ST_ERROR_MENU, piano_ctrl_pkg::ST_SHOW_LAST);
    hold_in(piano_ctrl_pkg::ST_SHOW_LAST, random_cycles(3));
    check_flag("cmd.leds_from_memory", cmd.leds_from_memory, 1'b1);
    status.beat_low = 1'b1;
    step_to(piano_ctrl_pkg::ST_ANSWER_WAIT);
    status.beat_low = 1'b0;
    check_flag("cmd.leds_from_memory", cmd.leds_from_memory, 1'b0);
    check_player("player", player, 3'b001);
endtask

task automatic round_end_song_end();
    answer_note(1'b1, 1'b1, 1'b0, piano_ctrl_pkg::ST_ADD_NOTE);
    step_to(piano_ctrl_pkg::ST_SAVE_ROUND);
    step_to(piano_ctrl_pkg::ST_CHECK_END);
    step_to(piano_ctrl_pkg::ST_NEXT_ROUND);
    check_flag("cmd.clear_show_delay", cmd.clear_show_delay, 1'b1);
    step_to(piano_ctrl_pkg::ST_START_ROUND);
    check_flag("cmd.count_show_delay", cmd.count_show_delay, 1'b1);
    show_melody(2);
    answer_note(1'b1, 1'b0, 1'b0, piano_ctrl_pkg::ST_NEXT_NOTE);
    step_to(piano_ctrl_pkg::ST_ANSWER_WAIT);
    answer_note(1'b1, 1'b1, 1'b0, piano_ctrl_pkg::ST_ADD_NOTE);
    step_to(piano_ctrl_pkg::ST_SAVE_ROUND);
    step_to(piano_ctrl_pkg::ST_CHECK_END);
    status.song_end = 1'b1;
    step_to(piano_ctrl_pkg::ST_WON_GAME);
    status.song_end = 1'b0;
    check_player("player", player, 3'b100);
endtask

task automatic free_play_keys();
    int hold;
    int gap;
    walk_menu(piano_ctrl_pkg::MODE_FREE);
    step_to(piano_ctrl_pkg::ST_FREE_WAIT);
    for (int k = 0; k < 3; k++) begin
        hold = random_cycles(5);
        gap  = random_cycles(3);
        // Outputs show the key level sampled one edge earlier
        for (int c = 0; c < hold + gap; c++) begin
            status.note_held = (c < hold);
            @(negedge clock);
            check_flag("cmd.play_tone", cmd.play_tone, status.note_held);
            check_flag("cmd.leds_on", cmd.leds_on, status.note_held);
        end
    end
endtask

// File: verif/tb_piano_control.sv
module tb_piano_control;

    localparam int CLOCK_PERIOD = 40;
    localparam int RESET_CYCLES = 4;

    // Worst case cycles of each directed test
    localparam int MENU_CYCLES    = 30;
    localparam int ROUND_CYCLES   = 50;
    localparam int ERROR_CYCLES   = 60;
    localparam int TIMEOUT_CYCLES = 20;
    localparam int END_CYCLES     = 60;
    localparam int FREE_CYCLES    = 50;
    localparam int TEST_CYCLES    = RESET_CYCLES + MENU_CYCLES + ROUND_CYCLES
                                  + ERROR_CYCLES + TIMEOUT_CYCLES + END_CYCLES
                                  + FREE_CYCLES;

    logic                           clock;
    logic                           reset;
    logic                           start;
    logic                           enter;
    piano_ctrl_pkg::play_mode_t     mode;
    piano_ctrl_pkg::retry_t         retry;
    piano_ctrl_pkg::ctrl_status_t   status;
    piano_ctrl_pkg::ctrl_cmd_t      cmd;
    piano_ctrl_pkg::player_status_t player;
    piano_ctrl_pkg::ctrl_state_t    debug_state;
    logic [31:0]                    lcg_state;

    `include "tb_piano_tasks.svh"

    piano_control dut_i (
        .clock       (clock),
        .reset       (reset),
        .start       (start),
        .enter       (enter),
        .mode        (mode),
        .retry       (retry),
        .status      (status),
        .cmd         (cmd),
        .player      (player),
        .debug_state (debug_state)
    );

    initial begin
        clock = 1'b0;
        forever #(CLOCK_PERIOD / 2) clock = ~clock;
    end

    initial begin
        #(TEST_CYCLES * 4 * CLOCK_PERIOD);
        fail_run("Watchdog expired before the test sequence finished");
    end

    // ----------------------------------------------------------------------
    // Test sequence
    // ----------------------------------------------------------------------
    initial begin
        reset     = 1'b1;
        start     = 1'b0;
        enter     = 1'b0;
        mode      = piano_ctrl_pkg::MODE_REPEAT;
        retry     = piano_ctrl_pkg::RETRY_NONE;
        status    = '0;
        lcg_state = 32'h5a15_a785;
        repeat (RESET_CYCLES) @(negedge clock);
        reset = 1'b0;

        reset_and_setup_pages();
        won_first_round();
        wrong_note_retry();
        timeout_show_last();
        round_end_song_end();
        free_play_keys();

        $display("Test passed");
        $finish;
    end

endmodule

// File: sources.f
+incdir+common
+incdir+verif
common/piano_ctrl_pkg.sv
control/menu_next_state.sv
control/play_next_state.sv
control/state_register.sv
control/command_decoder.sv
control/piano_control.sv
verif/tb_piano_control.sv

// File: Bender.yml
package:
  name: piano_control

sources:
  - include_dirs:
      - common
    files:
      - common/piano_ctrl_pkg.sv
      - control/menu_next_state.sv
      - control/play_next_state.sv
      - control/state_register.sv
      - control/command_decoder.sv
      - control/piano_control.sv
  - target: test
    include_dirs:
      - common
      - verif
    files:
      - verif/tb_piano_control.sv
